//--- sources.f
rtl/rename_pkg.sv
rtl/checkpoint_if.sv
rtl/free_list.sv
rtl/checkpoint_store.sv
rtl/alias_table.sv
rtl/rename_stage.sv
verification/rename_checker.sv
verification/rename_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the rename stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rename_tb \
    -f sources.f -o rename_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/rename_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
exit 1

//--- verification/rename_tb.sv
`timescale 1ns/100ps

module rename_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RANDOM_LEN   = 400;
    localparam int DIRECTED_LEN = 150;  // tests 1 to 5 and the reset, with room to spare
    localparam int MARGIN       = 50;
    localparam rename_pkg::opcode_t OP_REG = 7'b0110011;  // R-type ALU, reads both sources

    logic                  clk;
    logic                  reset;
    rename_pkg::opcode_t   opcode;
    rename_pkg::log_reg_t  logical_addr1, logical_addr2, rd_logical_addr;
    logic                  if_id_flush, save_state, restore_state;
    rename_pkg::page_t     save_page, restore_page;
    rename_pkg::phys_tag_t phy_addr_out1, phy_addr_out2, rd_phy_out;
    integer                seed;
    int                    r;

    rename_stage uut (.*);
    rename_checker chk (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic rename_pkg::opcode_t opcode_for(int idx);
        case (idx)
            0: return rename_pkg::OP_JALR;
            1: return rename_pkg::OP_LOAD;
            2: return rename_pkg::OP_IMM;
            3: return rename_pkg::OP_LUI;
            4: return rename_pkg::OP_AUIPC;
            5: return rename_pkg::OP_JAL;
            6: return rename_pkg::OP_BRANCH;
            7: return rename_pkg::OP_STORE;
            8: return rename_pkg::OP_BUBBLE;
            default: return OP_REG;
        endcase
    endfunction

    // strobes are cleared here and set by the caller in the same time step when needed
    task automatic issue(input rename_pkg::opcode_t op, input int a1, input int a2, input int rd);
        @(negedge clk);
        opcode          = op;
        logical_addr1   = a1[4:0];
        logical_addr2   = a2[4:0];
        rd_logical_addr = rd[4:0];
        if_id_flush     = 1'b0;
        save_state      = 1'b0;
        restore_state   = 1'b0;
    endtask

    task automatic end_test(input string name);
        issue(rename_pkg::OP_BUBBLE, 0, 0, 0);
        @(posedge clk);  // the last instruction has been compared by now
        chk.report_test(name);
    endtask

    initial begin
        seed = 44;
        clk = 1'b0;
        reset = 1'b1;
        {opcode, logical_addr1, logical_addr2, rd_logical_addr} = '0;
        {if_id_flush, save_state, save_page, restore_state, restore_page} = '0;
        repeat (2) @(posedge clk);
        @(negedge clk) reset = 1'b0;

        issue(OP_REG, 1, 2, 0);
        for (int i = 0; i < 4; i++)
            issue(OP_REG, 2 * i + 3, 2 * i + 4, 10 + i);  // new tags 32, 33, 34, 35
        issue(OP_REG, 10, 11, 0);
        end_test("1 reset and first allocations");

        for (int i = 0; i < 10; i++)
            issue(opcode_for(i), 3, 4, 14);
        issue(OP_REG, 14, 3, 0);
        end_test("2 operand selection by opcode");

        issue(rename_pkg::OP_IMM, 1, 0, 5);
        issue(OP_REG, 5, 5, 0);
        for (int i = 0; i < 34; i++)
            issue(rename_pkg::OP_IMM, i % 32, 0, 1 + i % 31);  // uses up the reset tags
        issue(OP_REG, 5, 1, 6);
        issue(rename_pkg::OP_LUI, 0, 0, 7);
        end_test("3 remap and release order");

        for (int i = 0; i < 2; i++) begin
            issue(rename_pkg::OP_IMM, 2, 0, 20);
            if_id_flush = 1'b1;
        end
        issue(OP_REG, 20, 2, 21);
        end_test("4 flush");

        issue(rename_pkg::OP_IMM, 1, 0, 7);
        save_state = 1'b1;
        save_page  = 3'd2;
        issue(rename_pkg::OP_IMM, 1, 0, 7);
        issue(rename_pkg::OP_IMM, 2, 0, 8);
        issue(OP_REG, 7, 8, 9);
        restore_state = 1'b1;
        restore_page  = 3'd2;
        issue(OP_REG, 7, 9, 0);
        end_test("5 save and restore");

        for (int n = 0; n < RANDOM_LEN; n++) begin
            r = $random(seed);
            issue(opcode_for(r[3:0] % 10), $random(seed), $random(seed), $random(seed));
            r = $random(seed);
            if_id_flush   = (r[2:0] == 3'd0);
            save_state    = (r[5:3] < 3'd2);
            save_page     = r[8:6];
            restore_state = (r[11:9] == 3'd1);
            restore_page  = (r[14:12] == r[8:6]) ? r[14:12] + 3'd1 : r[14:12];
        end
        end_test("6 random mix");

        chk.report_totals();
        if (chk.error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #((DIRECTED_LEN + RANDOM_LEN + MARGIN) * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 DIRECTED_LEN + RANDOM_LEN + MARGIN);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verification/rename_checker.sv
`timescale 1ns/100ps

module rename_checker (
    input logic                  clk,
    input logic                  reset,
    input rename_pkg::opcode_t   opcode,
    input rename_pkg::log_reg_t  logical_addr1,
    input rename_pkg::log_reg_t  logical_addr2,
    input rename_pkg::log_reg_t  rd_logical_addr,
    input logic                  if_id_flush,
    input logic                  save_state,
    input rename_pkg::page_t     save_page,
    input logic                  restore_state,
    input rename_pkg::page_t     restore_page,
    input rename_pkg::phys_tag_t phy_addr_out1,
    input rename_pkg::phys_tag_t phy_addr_out2,
    input rename_pkg::phys_tag_t rd_phy_out
);

    rename_pkg::phys_tag_t model_map [rename_pkg::NUM_LOG_REGS];
    rename_pkg::phys_tag_t lookup_map [rename_pkg::NUM_LOG_REGS];  // map seen this cycle
    rename_pkg::phys_tag_t model_pages [rename_pkg::NUM_PAGES][rename_pkg::NUM_LOG_REGS];
    rename_pkg::phys_tag_t free_q [$];                             // free tags, head first
    rename_pkg::phys_tag_t exp_src1, exp_src2, exp_dst;
    logic                  armed = 1'b0;                           // expected values are known
    int                    check_count = 0;
    int                    error_count = 0;
    int                    test_start_errors = 0;

    // expected {src1, src2, dst} for one instruction, given the tags its sources map to
    function automatic logic [23:0] expected_outputs(rename_pkg::opcode_t op,
            rename_pkg::phys_tag_t tag1, rename_pkg::phys_tag_t tag2,
            rename_pkg::log_reg_t rd, rename_pkg::phys_tag_t head);
        rename_pkg::phys_tag_t s1, s2, d;
        s1 = tag1;
        s2 = tag2;
        d  = rename_pkg::TAG_NO_DST;
        if (op == rename_pkg::OP_JALR || op == rename_pkg::OP_LOAD || op == rename_pkg::OP_IMM)
            s2 = rename_pkg::TAG_NO_SRC;                          // rs2 is an immediate here
        if (op == rename_pkg::OP_LUI || op == rename_pkg::OP_AUIPC || op == rename_pkg::OP_JAL) begin
            s1 = rename_pkg::TAG_NO_SRC;
            s2 = rename_pkg::TAG_NO_SRC;
        end
        if (op != rename_pkg::OP_BRANCH && op != rename_pkg::OP_STORE &&
            op != rename_pkg::OP_BUBBLE && rd != 5'd0)
            d = head;
        return {s1, s2, d};
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < rename_pkg::NUM_LOG_REGS; k++) begin
                model_map[k] = rename_pkg::phys_tag_t'(k);
                for (int p = 0; p < rename_pkg::NUM_PAGES; p++)
                    model_pages[p][k] = rename_pkg::phys_tag_t'(k);
            end
            free_q.delete();
            for (int t = rename_pkg::NUM_LOG_REGS; t < rename_pkg::NUM_PHYS_REGS; t++)
                free_q.push_back(rename_pkg::phys_tag_t'(t));
            {exp_src1, exp_src2, exp_dst} = {rename_pkg::TAG_NO_SRC, rename_pkg::TAG_NO_SRC,
                                             rename_pkg::TAG_NO_DST};
            armed = 1'b1;
        end else if (!if_id_flush) begin  // a flushed slot leaves the model and outputs alone
            for (int k = 0; k < rename_pkg::NUM_LOG_REGS; k++)
                lookup_map[k] = restore_state ? model_pages[restore_page][k] : model_map[k];
            if (save_state) begin
                for (int k = 0; k < rename_pkg::NUM_LOG_REGS; k++)
                    model_pages[save_page][k] = model_map[k];    // contents before the remap
            end
            {exp_src1, exp_src2, exp_dst} = expected_outputs(opcode, lookup_map[logical_addr1],
                lookup_map[logical_addr2], rd_logical_addr, free_q[0]);
            model_map = lookup_map;
            if (exp_dst != rename_pkg::TAG_NO_DST) begin
                void'(free_q.pop_front());
                free_q.push_back(lookup_map[rd_logical_addr]);   // old tag goes to the tail
                model_map[rd_logical_addr] = exp_dst;
            end
        end
    end

    task automatic compare(input string name, input rename_pkg::phys_tag_t expected,
                           input rename_pkg::phys_tag_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0d ns: %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    // outputs settle after the rising edge, so the falling edge sees stable values
    always @(negedge clk) begin
        if (armed) begin
            compare("phy_addr_out1", exp_src1, phy_addr_out1);
            compare("phy_addr_out2", exp_src2, phy_addr_out2);
            compare("rd_phy_out", exp_dst, rd_phy_out);
        end
    end

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    task automatic report_totals();
        $display("%0d checks, %0d errors", check_count, error_count);
    endtask

endmodule

//--- rtl/rename_stage.sv
`timescale 1ns/100ps

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::opcode_t   opcode,
    input  rename_pkg::log_reg_t  logical_addr1,
    input  rename_pkg::log_reg_t  logical_addr2,
    input  rename_pkg::log_reg_t  rd_logical_addr,
    input  logic                  if_id_flush,
    input  logic                  save_state,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore_state,
    input  rename_pkg::page_t     restore_page,
    output rename_pkg::phys_tag_t phy_addr_out1,
    output rename_pkg::phys_tag_t phy_addr_out2,
    output rename_pkg::phys_tag_t rd_phy_out
);

    logic                  alloc;
    logic                  release_en;
    rename_pkg::phys_tag_t release_tag;
    rename_pkg::phys_tag_t head_tag;

    checkpoint_if ckpt ();  // snapshot path between the table and the page store

    alias_table u_alias_table (
        .clk             (clk),
        .reset           (reset),
        .opcode          (opcode),
        .logical_addr1   (logical_addr1),
        .logical_addr2   (logical_addr2),
        .rd_logical_addr (rd_logical_addr),
        .if_id_flush     (if_id_flush),
        .save_state      (save_state),
        .save_page       (save_page),
        .restore_state   (restore_state),
        .restore_page    (restore_page),
        .head_tag        (head_tag),
        .alloc           (alloc),
        .release_en      (release_en),
        .release_tag     (release_tag),
        .phy_addr_out1   (phy_addr_out1),
        .phy_addr_out2   (phy_addr_out2),
        .rd_phy_out      (rd_phy_out),
        .ckpt            (ckpt.table_side)
    );

    free_list u_free_list (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .release_en  (release_en),
        .release_tag (release_tag),
        .head_tag    (head_tag)
    );

    checkpoint_store u_checkpoint_store (
        .clk   (clk),
        .reset (reset),
        .ckpt  (ckpt.store_side)
    );

endmodule

//--- rtl/alias_table.sv
`timescale 1ns/100ps

module alias_table (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::opcode_t   opcode,
    input  rename_pkg::log_reg_t  logical_addr1,
    input  rename_pkg::log_reg_t  logical_addr2,
    input  rename_pkg::log_reg_t  rd_logical_addr,
    input  logic                  if_id_flush,
    input  logic                  save_state,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore_state,
    input  rename_pkg::page_t     restore_page,
    input  rename_pkg::phys_tag_t head_tag,       // next free tag from the free list
    output logic                  alloc,
    output logic                  release_en,
    output rename_pkg::phys_tag_t release_tag,
    output rename_pkg::phys_tag_t phy_addr_out1,
    output rename_pkg::phys_tag_t phy_addr_out2,
    output rename_pkg::phys_tag_t rd_phy_out,
    checkpoint_if.table_side      ckpt
);

    rename_pkg::snapshot_t table_q;     // current logical to physical map
    rename_pkg::snapshot_t lookup;      // map that this cycle's instruction reads
    rename_pkg::snapshot_t table_next;  // lookup with the new destination applied
    logic                  active;
    logic                  do_restore;
    logic                  use_src1;
    logic                  use_src2;
    logic                  has_dst;

    assign active     = !if_id_flush;                  // a flushed slot touches nothing
    assign do_restore = restore_state && active;
    assign lookup     = do_restore ? ckpt.restore_data : table_q;

    assign ckpt.save         = save_state && active;
    assign ckpt.save_page    = save_page;
    assign ckpt.restore      = do_restore;
    assign ckpt.restore_page = restore_page;
    assign ckpt.save_data    = table_q;                // contents before this cycle's remap

    always_comb begin
        use_src1 = 1'b1;
        use_src2 = 1'b1;
        case (opcode)
            rename_pkg::OP_JALR, rename_pkg::OP_LOAD, rename_pkg::OP_IMM: begin
                use_src2 = 1'b0;                       // immediate takes the rs2 slot
            end
            rename_pkg::OP_LUI, rename_pkg::OP_AUIPC, rename_pkg::OP_JAL: begin
                use_src1 = 1'b0;
                use_src2 = 1'b0;
            end
            default: begin
                use_src1 = 1'b1;
                use_src2 = 1'b1;
            end
        endcase
    end

    // branches, stores and bubbles write no register, and x0 is never renamed
    assign has_dst = (opcode != rename_pkg::OP_BRANCH) &&
                     (opcode != rename_pkg::OP_STORE) &&
                     (opcode != rename_pkg::OP_BUBBLE) &&
                     (rd_logical_addr != '0);

    assign alloc       = active && has_dst;
    assign release_en  = active && has_dst;            // the displaced tag is freed right away
    assign release_tag = rename_pkg::get_tag(lookup, rd_logical_addr);

    always_comb begin
        table_next = lookup;
        if (has_dst) begin
            table_next[rd_logical_addr*rename_pkg::TAG_W +: rename_pkg::TAG_W] = head_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            table_q       <= rename_pkg::identity_snapshot();
            phy_addr_out1 <= rename_pkg::TAG_NO_SRC;
            phy_addr_out2 <= rename_pkg::TAG_NO_SRC;
            rd_phy_out    <= rename_pkg::TAG_NO_DST;
        end else if (active) begin
            table_q       <= table_next;
            phy_addr_out1 <= use_src1 ? rename_pkg::get_tag(lookup, logical_addr1)
                                      : rename_pkg::TAG_NO_SRC;
            phy_addr_out2 <= use_src2 ? rename_pkg::get_tag(lookup, logical_addr2)
                                      : rename_pkg::TAG_NO_SRC;
            rd_phy_out    <= has_dst ? head_tag : rename_pkg::TAG_NO_DST;
        end
    end

    // the free list must only ever hand out real physical registers
    a_dst_not_sentinel: assert property (
        @(posedge clk) disable iff (reset)
        alloc |=> (rd_phy_out != rename_pkg::TAG_NO_SRC) &&
                  (rd_phy_out != rename_pkg::TAG_NO_DST)
    ) else $error("destination renamed to sentinel tag %0d", rd_phy_out);

endmodule

//--- rtl/checkpoint_store.sv
`timescale 1ns/100ps

module checkpoint_store (
    input  logic                    clk,
    input  logic                    reset,
    checkpoint_if.store_side        ckpt
);

    rename_pkg::snapshot_t pages [rename_pkg::NUM_PAGES];  // one full alias table per page

    // a restore sees the page as it stands before this edge
    assign ckpt.restore_data = pages[ckpt.restore_page];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < rename_pkg::NUM_PAGES; p++) begin
                pages[p] <= rename_pkg::identity_snapshot();
            end
        end else if (ckpt.save) begin
            pages[ckpt.save_page] <= ckpt.save_data;
        end
    end

    // writing and reading one page in the same cycle would make the restored
    // contents depend on which side wins, so the front end must keep them apart
    a_save_restore_distinct: assert property (
        @(posedge clk) disable iff (reset)
        (ckpt.save && ckpt.restore) |-> (ckpt.save_page != ckpt.restore_page)
    ) else $error("save and restore target page %0d together", ckpt.save_page);

endmodule

//--- rtl/free_list.sv
`timescale 1ns/100ps

module free_list (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc,        // pop the head tag at this edge
    input  logic                  release_en,   // push release_tag at the tail at this edge
    input  rename_pkg::phys_tag_t release_tag,
    output rename_pkg::phys_tag_t head_tag
);

    rename_pkg::phys_tag_t            fifo_mem [rename_pkg::NUM_PHYS_REGS];
    logic [rename_pkg::FL_PTR_W-1:0]  head_ptr;
    logic [rename_pkg::FL_PTR_W-1:0]  tail_ptr;
    logic [rename_pkg::FL_PTR_W:0]    count;      // one extra bit so a full FIFO can be counted

    assign head_tag = fifo_mem[head_ptr];  // next tag to hand out, no read latency

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::NUM_PHYS_REGS; i++) begin
                if (i < rename_pkg::NUM_PHYS_REGS - rename_pkg::NUM_LOG_REGS) begin
                    // tags above the identity mapping start out free, lowest first
                    fifo_mem[i] <= rename_pkg::phys_tag_t'(i + rename_pkg::NUM_LOG_REGS);
                end else begin
                    fifo_mem[i] <= '0;
                end
            end
        end else if (release_en) begin
            fifo_mem[tail_ptr] <= release_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= rename_pkg::FL_PTR_W'(rename_pkg::NUM_PHYS_REGS - rename_pkg::NUM_LOG_REGS);
            count    <= (rename_pkg::FL_PTR_W + 1)'(rename_pkg::NUM_PHYS_REGS -
                                                   rename_pkg::NUM_LOG_REGS);
        end else begin
            if (alloc) begin
                head_ptr <= head_ptr + 1'b1;  // pointers wrap on their own at 64
            end
            if (release_en) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            case ({alloc, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;       // paired pop and push leave it unchanged
            endcase
        end
    end

    // the rename stage pairs every pop with a push, so these only fire on a broken pairing
    a_no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        alloc |-> (count != '0)
    ) else $error("free list popped while empty");

    a_no_release_when_full: assert property (
        @(posedge clk) disable iff (reset)
        (release_en && !alloc) |-> (count != (rename_pkg::FL_PTR_W + 1)'(rename_pkg::NUM_PHYS_REGS))
    ) else $error("free list pushed while full");

endmodule

//--- rtl/checkpoint_if.sv
`timescale 1ns/100ps

interface checkpoint_if;

    logic                  save;          // write save_data into save_page this edge
    rename_pkg::page_t     save_page;
    logic                  restore;       // restore_page is being loaded this cycle
    rename_pkg::page_t     restore_page;
    rename_pkg::snapshot_t save_data;
    rename_pkg::snapshot_t restore_data;

    modport table_side (
        output save,
        output save_page,
        output restore,
        output restore_page,
        output save_data,
        input  restore_data
    );

    modport store_side (
        input  save,
        input  save_page,
        input  restore,
        input  restore_page,
        input  save_data,
        output restore_data
    );

endinterface

//--- rtl/rename_pkg.sv
package rename_pkg;

    localparam int TAG_W         = 8;
    localparam int LOG_W         = 5;
    localparam int PAGE_W        = 3;
    localparam int OPCODE_W      = 7;

    localparam int NUM_LOG_REGS  = 32;
    localparam int NUM_PHYS_REGS = 64;
    localparam int NUM_PAGES     = 8;
    localparam int FL_PTR_W      = $clog2(NUM_PHYS_REGS);  // free list pointer width

    typedef logic [TAG_W-1:0]              phys_tag_t;
    typedef logic [LOG_W-1:0]              log_reg_t;
    typedef logic [PAGE_W-1:0]             page_t;
    typedef logic [OPCODE_W-1:0]           opcode_t;
    typedef logic [NUM_LOG_REGS*TAG_W-1:0] snapshot_t;  // entry k sits at bits [k*8 +: 8]

    localparam phys_tag_t TAG_NO_SRC = 8'd254;  // operand not read by this opcode
    localparam phys_tag_t TAG_NO_DST = 8'd255;  // no destination written

    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BUBBLE = 7'b0000000;

    // entry of one logical register inside a packed snapshot
    function automatic phys_tag_t get_tag(snapshot_t snap, log_reg_t idx);
        return snap[idx*TAG_W +: TAG_W];
    endfunction

    function automatic snapshot_t identity_snapshot();
        snapshot_t snap;
        for (int k = 0; k < NUM_LOG_REGS; k++) begin
            snap[k*TAG_W +: TAG_W] = phys_tag_t'(k);  // x<k> maps to tag k
        end
        return snap;
    endfunction

endpackage
